// File: rtl/sensor_pkg.sv
package sensor_pkg;

	// DRP master side, we and din stay low (read only)
	typedef struct packed {
		logic        en;
		logic        we;
		logic [6:0]  addr;
		logic [15:0] din;
	} drp_req_t;

	typedef struct packed {
		logic        ready;	// One-cycle pulse with dout
		logic        busy;	// ADC converting
		logic [15:0] dout;
	} drp_rsp_t;

	typedef enum logic {
		KIND_TEMP,
		KIND_VOLT
	} conv_kind_e;

	// Destination register of a converted value
	typedef enum logic [1:0] {
		TGT_TEMP,
		TGT_CORE,
		TGT_AUX,
		TGT_RAM
	} reg_target_e;

	typedef struct packed {
		logic        valid;
		conv_kind_e  kind;
		reg_target_e target;
		logic [3:0]  ext_idx;
		logic [11:0] code;	// Top 12 bits of the DRP word
	} scale_req_t;

	typedef struct packed {
		logic        valid;
		reg_target_e target;
		logic [3:0]  ext_idx;
		logic [15:0] value;	// 8.8 fixed point
	} scale_rsp_t;

	// Raw codes and completion flags, control to register bank
	typedef struct packed {
		logic        ext_valid;
		logic [3:0]  ext_idx;
		logic [11:0] code;
		logic        native_valid;
		logic        bank_done;
		logic        ext_done;
	} store_t;

	localparam logic [6:0] ADDR_TEMP    = 7'd0;
	localparam logic [6:0] ADDR_VCCINT  = 7'd1;
	localparam logic [6:0] ADDR_VCCAUX  = 7'd2;
	localparam logic [6:0] ADDR_VCCBRAM = 7'd6;
	localparam logic [6:0] ADDR_AUX0    = 7'd16;	// First of 16 aux results

	// temp = code * 503.975 / 4096 - 273.15
	localparam logic [17:0] TEMP_GAIN   = 18'h1F7F9;	// 503.975 in 9.8
	localparam logic [19:0] TEMP_OFFSET = 20'h11126;	// 273.15, radix at bit 8
	// volt = code * 3 / 4096
	localparam logic [17:0] VOLT_GAIN   = 18'd3;

endpackage

// File: rtl/adc_poll_ctrl.sv
`timescale 1ns/1ps

module adc_poll_ctrl #(
	parameter int PWRUP_CYCLES    = 256,
	parameter int WATCHDOG_CYCLES = 1023
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  sensor_pkg::drp_rsp_t   drp_rsp,
	input  logic                   scale_rsp_valid,
	output sensor_pkg::drp_req_t   drp_req,
	output logic                   adc_reset,
	output sensor_pkg::scale_req_t scale_req,
	output sensor_pkg::store_t     store
);

	localparam int PWR_W = $clog2(PWRUP_CYCLES + 1);
	localparam int WD_W  = $clog2(WATCHDOG_CYCLES + 1);

	typedef enum logic [3:0] {
		S_PWR_RST,	// ADC held in reset
		S_PWR_WAIT,	// ADC out of reset, settling
		S_TEMP_REQ,
		S_TEMP_WAIT,
		S_TEMP_CONV,
		S_VOLT_REQ,
		S_VOLT_WAIT,
		S_VOLT_CONV,
		S_EXT_REQ,
		S_EXT_WAIT
	} state_e;

	state_e                  state;
	logic [PWR_W-1:0]        pwr_cnt;
	logic [WD_W-1:0]         wd_cnt;	// Cycles spent in the external sweep
	logic                    wd_expired;
	logic                    rd_pending;	// DRP read issued, no ready yet
	logic                    conv_pending;	// Scaler request in flight
	logic [11:0]             code;
	sensor_pkg::reg_target_e rail_tgt;

	assign code       = drp_rsp.dout[15:4];	// Four LSBs dropped
	assign wd_expired = (wd_cnt == WD_W'(WATCHDOG_CYCLES));

	// Rail register follows the current DRP address
	always_comb begin
		case (drp_req.addr)
			sensor_pkg::ADDR_VCCAUX:  rail_tgt = sensor_pkg::TGT_AUX;
			sensor_pkg::ADDR_VCCBRAM: rail_tgt = sensor_pkg::TGT_RAM;
			default:                  rail_tgt = sensor_pkg::TGT_CORE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= S_PWR_RST;
			drp_req   <= '0;
			adc_reset <= 1'b1;
			pwr_cnt   <= '0;
			wd_cnt    <= '0;
		end else begin
			drp_req.en <= 1'b0;	// Enable is a single pulse
			case (state)
				S_PWR_RST: begin
					pwr_cnt <= pwr_cnt + 1'b1;
					if (pwr_cnt == PWR_W'(PWRUP_CYCLES - 1)) begin
						pwr_cnt   <= '0;
						adc_reset <= 1'b0;
						state     <= S_PWR_WAIT;
					end
				end
				S_PWR_WAIT: begin
					pwr_cnt <= pwr_cnt + 1'b1;
					if (pwr_cnt == PWR_W'(PWRUP_CYCLES - 1))
						state <= S_TEMP_REQ;
				end

				// Round starts here, also after a watchdog abort
				S_TEMP_REQ: begin
					if (!drp_rsp.busy) begin
						drp_req.en   <= 1'b1;
						drp_req.addr <= sensor_pkg::ADDR_TEMP;
						state        <= S_TEMP_WAIT;
					end
				end
				S_TEMP_WAIT: if (drp_rsp.ready) state <= S_TEMP_CONV;
				S_TEMP_CONV: begin
					if (scale_rsp_valid) begin
						drp_req.addr <= sensor_pkg::ADDR_VCCINT;
						state        <= S_VOLT_REQ;
					end
				end

				// Rails, VCCINT then VCCAUX then VCCBRAM
				S_VOLT_REQ: begin
					if (!drp_rsp.busy) begin
						drp_req.en <= 1'b1;
						state      <= S_VOLT_WAIT;
					end
				end
				S_VOLT_WAIT: if (drp_rsp.ready) state <= S_VOLT_CONV;
				S_VOLT_CONV: begin
					if (scale_rsp_valid) begin
						if (drp_req.addr == sensor_pkg::ADDR_VCCBRAM) begin
							drp_req.addr <= sensor_pkg::ADDR_AUX0;
							wd_cnt       <= '0;	// Arm watchdog for the sweep
							state        <= S_EXT_REQ;
						end else begin
							drp_req.addr <= (drp_req.addr == sensor_pkg::ADDR_VCCINT) ?
								sensor_pkg::ADDR_VCCAUX : sensor_pkg::ADDR_VCCBRAM;
							state        <= S_VOLT_REQ;
						end
					end
				end

				// External sweep, addresses 16 to 31
				S_EXT_REQ: begin
					wd_cnt <= wd_cnt + 1'b1;
					if (wd_expired)
						state <= S_TEMP_REQ;
					else if (!drp_rsp.busy) begin
						drp_req.en <= 1'b1;
						state      <= S_EXT_WAIT;
					end
				end
				S_EXT_WAIT: begin
					wd_cnt <= wd_cnt + 1'b1;
					if (drp_rsp.ready) begin
						if (drp_req.addr[3:0] == 4'hf)
							state <= S_TEMP_REQ;	// Sweep complete
						else begin
							drp_req.addr <= drp_req.addr + 1'b1;
							state        <= S_EXT_REQ;
						end
					end else if (wd_expired)
						state <= S_TEMP_REQ;	// Stuck read, abandon round
				end
				default: state <= S_PWR_RST;
			endcase
		end
	end

	// Combinational so the register bank writes on the edge after ready
	always_comb begin
		scale_req = '0;
		store     = '0;
		case (state)
			S_TEMP_WAIT: begin
				scale_req.valid    = drp_rsp.ready;
				scale_req.kind     = sensor_pkg::KIND_TEMP;
				scale_req.target   = sensor_pkg::TGT_TEMP;
				scale_req.code     = code;
				store.native_valid = drp_rsp.ready;	// Raw temp code for the MIG
				store.code         = code;
			end
			S_VOLT_WAIT: begin
				scale_req.valid  = drp_rsp.ready;
				scale_req.kind   = sensor_pkg::KIND_VOLT;
				scale_req.target = rail_tgt;
				scale_req.code   = code;
			end
			S_VOLT_CONV: begin
				store.bank_done = scale_rsp_valid &&
					(drp_req.addr == sensor_pkg::ADDR_VCCBRAM);
			end
			S_EXT_WAIT: begin
				store.ext_valid = drp_rsp.ready;
				store.ext_idx   = drp_req.addr[3:0];
				store.code      = code;
				store.ext_done  = drp_rsp.ready && (drp_req.addr[3:0] == 4'hf);
			end
			default: ;
		endcase
	end

	// Outstanding read and conversion trackers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_pending   <= 1'b0;
			conv_pending <= 1'b0;
		end else begin
			if (drp_req.en)
				rd_pending <= 1'b1;
			else if (drp_rsp.ready || (state == S_EXT_WAIT && wd_expired))
				rd_pending <= 1'b0;
			if (scale_req.valid)
				conv_pending <= 1'b1;
			else if (scale_rsp_valid)
				conv_pending <= 1'b0;
		end
	end

	a_single_read: assert property (@(posedge clk) disable iff (!rst_n)
		drp_req.en |-> !rd_pending);
	a_single_conv: assert property (@(posedge clk) disable iff (!rst_n)
		scale_req.valid |-> !conv_pending);

endmodule

// File: rtl/sensor_scaler.sv
`timescale 1ns/1ps

module sensor_scaler (
	input  logic                   clk,
	input  logic                   rst_n,
	input  sensor_pkg::scale_req_t req,
	output sensor_pkg::scale_rsp_t rsp
);

	// Payload travelling down the multiplier pipe
	typedef struct packed {
		sensor_pkg::conv_kind_e  kind;
		sensor_pkg::reg_target_e target;
		logic [3:0]              ext_idx;
		logic [29:0]             prod;	// 12 x 18 bits
	} stage_t;

	logic [2:0]  vld;	// One bit per stage
	stage_t      st [3];
	logic [17:0] gain;
	logic [19:0] temp_full;
	logic [15:0] temp_val;
	logic [15:0] volt_val;

	assign gain = (req.kind == sensor_pkg::KIND_TEMP) ?
		sensor_pkg::TEMP_GAIN : sensor_pkg::VOLT_GAIN;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			vld <= '0;
		else
			vld <= {vld[1:0], req.valid};
	end

	// Multiply in stage 0 and retime through two more stages into the DSP
	always_ff @(posedge clk) begin
		st[0].kind    <= req.kind;
		st[0].target  <= req.target;
		st[0].ext_idx <= req.ext_idx;
		st[0].prod    <= 30'(req.code) * 30'(gain);
		st[1]         <= st[0];
		st[2]         <= st[1];
	end

	// Dropping 12 bits divides by 4096 and puts the radix at bit 8
	assign temp_full = {2'b00, st[2].prod[29:12]} - sensor_pkg::TEMP_OFFSET;
	assign temp_val  = temp_full[15:0];
	// Divide by 4096 and keep 8 fraction bits for a net shift of 4
	assign volt_val  = st[2].prod[19:4];

	always_comb begin
		rsp.valid   = vld[2];
		rsp.target  = st[2].target;
		rsp.ext_idx = st[2].ext_idx;
		rsp.value   = (st[2].kind == sensor_pkg::KIND_TEMP) ? temp_val : volt_val;
	end

	// Temperature transfer only ever feeds the temperature register
	a_kind_target: assert property (@(posedge clk) disable iff (!rst_n)
		req.valid |-> ((req.kind == sensor_pkg::KIND_TEMP) ==
			(req.target == sensor_pkg::TGT_TEMP)));

endmodule

// File: rtl/sensor_regs.sv
`timescale 1ns/1ps

module sensor_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  sensor_pkg::scale_rsp_t rsp,
	input  sensor_pkg::store_t     store,
	output logic [15:0]            die_temp,	// Degrees C in 8.8
	output logic [15:0]            volt_core,	// VCCINT
	output logic [15:0]            volt_aux,	// VCCAUX
	output logic [15:0]            volt_ram,	// VCCBRAM
	output logic [191:0]           ext_in,	// ADn at n*12 +: 12
	output logic [11:0]            die_temp_native,
	output logic                   sensors_update,
	output logic                   ext_update
);

	// Converted values from the scaler
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			die_temp  <= '0;
			volt_core <= '0;
			volt_aux  <= '0;
			volt_ram  <= '0;
		end else if (rsp.valid) begin
			case (rsp.target)
				sensor_pkg::TGT_TEMP: die_temp  <= rsp.value;
				sensor_pkg::TGT_CORE: volt_core <= rsp.value;
				sensor_pkg::TGT_AUX:  volt_aux  <= rsp.value;
				sensor_pkg::TGT_RAM:  volt_ram  <= rsp.value;
				default: ;
			endcase
		end
	end

	// Raw codes straight from the DRP
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ext_in          <= '0;
			die_temp_native <= '0;
		end else begin
			if (store.ext_valid)
				ext_in[store.ext_idx * 12 +: 12] <= store.code;
			if (store.native_valid)
				die_temp_native <= store.code;
		end
	end

	// Strobes land on the same edge as the last value of their group
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sensors_update <= 1'b0;
			ext_update     <= 1'b0;
		end else begin
			sensors_update <= store.bank_done;
			ext_update     <= store.ext_done;
		end
	end

	// Converted temperature pairs with the raw code stored three cycles earlier
	a_temp_pair: assert property (@(posedge clk) disable iff (!rst_n)
		(rsp.valid && rsp.target == sensor_pkg::TGT_TEMP) |-> $past(store.native_valid, 3));

	// Rail group completes only while the last rail is written
	a_bank_done_ram: assert property (@(posedge clk) disable iff (!rst_n)
		store.bank_done |-> (rsp.valid && rsp.target == sensor_pkg::TGT_RAM));

endmodule

// File: rtl/on_die_sensors.sv
`timescale 1ns/1ps

module on_die_sensors #(
	parameter int PWRUP_CYCLES    = 256,	// Per power-up phase
	parameter int WATCHDOG_CYCLES = 1023	// External sweep limit
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  sensor_pkg::drp_rsp_t drp_rsp,
	output sensor_pkg::drp_req_t drp_req,
	output logic                 adc_reset,
	output logic [15:0]          die_temp,
	output logic [15:0]          volt_core,
	output logic [15:0]          volt_aux,
	output logic [15:0]          volt_ram,
	output logic [191:0]         ext_in,
	output logic [11:0]          die_temp_native,
	output logic                 sensors_update,
	output logic                 ext_update
);

	sensor_pkg::scale_req_t scale_req;
	sensor_pkg::scale_rsp_t scale_rsp;
	sensor_pkg::store_t     store;

	adc_poll_ctrl #(
		.PWRUP_CYCLES    (PWRUP_CYCLES),
		.WATCHDOG_CYCLES (WATCHDOG_CYCLES)
	) adc_poll_ctrl_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.drp_rsp         (drp_rsp),
		.scale_rsp_valid (scale_rsp.valid),	// Conversion done handshake
		.drp_req         (drp_req),
		.adc_reset       (adc_reset),
		.scale_req       (scale_req),
		.store           (store)
	);

	sensor_scaler sensor_scaler_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (scale_req),
		.rsp   (scale_rsp)
	);

	sensor_regs sensor_regs_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.rsp             (scale_rsp),
		.store           (store),
		.die_temp        (die_temp),
		.volt_core       (volt_core),
		.volt_aux        (volt_aux),
		.volt_ram        (volt_ram),
		.ext_in          (ext_in),
		.die_temp_native (die_temp_native),
		.sensors_update  (sensors_update),
		.ext_update      (ext_update)
	);

endmodule

// File: bench/drp_adc_model.sv
`timescale 1ns/1ps

module drp_adc_model (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [31:0][15:0]    code_table,	// Result word per DRP address
	input  logic [63:0][2:0]     delays,	// Ready delays, used in turn
	input  logic                 stall_arm,
	input  logic [6:0]           stall_addr,	// Read that never answers
	input  sensor_pkg::drp_req_t drp_req,
	output sensor_pkg::drp_rsp_t drp_rsp
);

	logic [2:0] wait_cnt;	// Cycles left until ready
	logic       stalled;
	logic       busy_hold;	// Keeps busy up a second cycle
	logic [6:0] addr;
	logic [5:0] dly_idx;

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			drp_rsp   <= '0;
			wait_cnt  <= '0;
			stalled   <= 1'b0;
			busy_hold <= 1'b0;
			addr      <= '0;
			dly_idx   <= '0;
		end else begin
			drp_rsp.ready <= 1'b0;	// Ready is a single pulse
			if (busy_hold)
				busy_hold <= 1'b0;
			else
				drp_rsp.busy <= 1'b0;

			// A new enable replaces any stalled read
			if (drp_req.en) begin
				addr     <= drp_req.addr;
				stalled  <= stall_arm && (drp_req.addr == stall_addr);
				wait_cnt <= delays[dly_idx];
				dly_idx  <= dly_idx + 1'b1;
			end else if (wait_cnt != 3'd0 && !stalled) begin
				wait_cnt <= wait_cnt - 1'b1;
				if (wait_cnt == 3'd1) begin
					drp_rsp.ready <= 1'b1;
					drp_rsp.dout  <= code_table[addr[4:0]];
					drp_rsp.busy  <= 1'b1;	// Next conversion running
					busy_hold     <= 1'b1;
				end
			end
		end
	end

endmodule

// File: bench/sensor_checker.sv
`timescale 1ns/1ps

module sensor_checker (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [8*16-1:0]   test_name,
	input  logic [31:0][15:0] code_table,	// Same table as the ADC model
	input  logic              expect_no_ext,	// Sweep due to be aborted
	input  logic              adc_reset,
	input  logic              drp_en,
	input  logic              drp_we,
	input  logic [15:0]       die_temp,
	input  logic [15:0]       volt_core,
	input  logic [15:0]       volt_aux,
	input  logic [15:0]       volt_ram,
	input  logic [191:0]      ext_in,
	input  logic [11:0]       die_temp_native,
	input  logic              sensors_update,
	input  logic              ext_update,
	output int                check_count,
	output int                error_count
);

	int checks  = 0;
	int errors  = 0;
	bit started = 1'b0;	// First cycle out of reset
	bit seen_en = 1'b0;	// First DRP read, end of power-up

	assign check_count = checks;
	assign error_count = errors;

	// 8.8 result from the top 12 bits of a DRP word
	function automatic logic [15:0] ref_convert(input bit is_temp, input logic [15:0] word);
		longint code;
		longint deg;
		code = longint'(word[15:4]);
		if (is_temp) begin
			deg = (code * 129017) >> 12;	// 503.975 * 256 / 4096
			return 16'(deg - 69926);	// Minus 273.15 * 256
		end
		return 16'((code * 3) >> 4);	// 3 V full scale
	endfunction

	task automatic check_value(input string field, input logic [15:0] exp_val,
		input logic [15:0] act_val);
		checks++;
		if (act_val !== exp_val) begin
			errors++;
			$display("[FAIL] %0s %0s expected %h actual %h", test_name, field, exp_val, act_val);
		end
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			if (!started) begin
				started = 1'b1;
				check_value("adc_reset", 16'd1, {15'd0, adc_reset});	// Held in reset first
			end

			// Nothing is published during power-up
			if (!seen_en) begin
				if (sensors_update || ext_update) begin
					errors++;
					$display("Error in %0s: update strobe during ADC power-up", test_name);
				end
				check_value("die_temp", 16'd0, die_temp);
				check_value("volt_core", 16'd0, volt_core);
				check_value("volt_aux", 16'd0, volt_aux);
				check_value("volt_ram", 16'd0, volt_ram);
				check_value("die_temp_native", 16'd0, {4'd0, die_temp_native});
				checks++;
				if (ext_in !== '0) begin
					errors++;
					$display("[FAIL] %0s ext_in expected 0 actual %h", test_name, ext_in);
				end
				if (drp_en) begin
					seen_en = 1'b1;
					check_value("adc_reset", 16'd0, {15'd0, adc_reset});
				end
			end

			if (drp_en)	// Reads only
				check_value("drp_we", 16'd0, {15'd0, drp_we});

			// Temperature sits at address 0 and the rails at 1, 2 and 6
			if (sensors_update) begin
				check_value("die_temp", ref_convert(1'b1, code_table[0]), die_temp);
				check_value("die_temp_native", {4'd0, code_table[0][15:4]},
					{4'd0, die_temp_native});
				check_value("volt_core", ref_convert(1'b0, code_table[1]), volt_core);
				check_value("volt_aux", ref_convert(1'b0, code_table[2]), volt_aux);
				check_value("volt_ram", ref_convert(1'b0, code_table[6]), volt_ram);
			end

			if (ext_update) begin
				if (expect_no_ext) begin
					errors++;
					$display("Error in %0s: ext_update arrived for a stalled sweep", test_name);
				end
				for (int n = 0; n < 16; n++)	// Channels from address 16 up
					check_value($sformatf("ext_in[%0d]", n), {4'd0, code_table[16 + n][15:4]},
						{4'd0, ext_in[n * 12 +: 12]});
			end
		end
	end

endmodule

// File: bench/tb_on_die_sensors.sv
`timescale 1ns/1ps

module tb_on_die_sensors;

	localparam int PWRUP_CYCLES    = 16;
	localparam int WATCHDOG_CYCLES = 200;
	localparam int ROUND_LIMIT     = 800;	// Well above one full round
	localparam int EV_BANK         = 0;
	localparam int EV_EXT          = 1;
	localparam int EV_RESET_LOW    = 2;
	localparam int EV_FIRST_READ   = 3;

	logic                 clk = 1'b0;
	logic                 rst_n;
	sensor_pkg::drp_req_t drp_req;
	sensor_pkg::drp_rsp_t drp_rsp;
	logic                 adc_reset;
	logic [15:0]          die_temp;
	logic [15:0]          volt_core;
	logic [15:0]          volt_aux;
	logic [15:0]          volt_ram;
	logic [191:0]         ext_in;
	logic [11:0]          die_temp_native;
	logic                 sensors_update;
	logic                 ext_update;
	logic [31:0][15:0]    code_table;
	logic [63:0][2:0]     delays;
	logic                 stall_arm;
	logic                 expect_no_ext;
	logic [8*16-1:0]      test_name;
	logic [31:0]          lfsr_state = 32'h8bce07bd;
	int                   check_count;
	int                   error_count;
	int                   base_checks = 0;
	int                   base_errors = 0;
	bit                   hung = 1'b0;	// A wait ran out

	always #4 clk = ~clk;	// 125 MHz

	on_die_sensors #(
		.PWRUP_CYCLES    (PWRUP_CYCLES),
		.WATCHDOG_CYCLES (WATCHDOG_CYCLES)
	) on_die_sensors_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.drp_rsp         (drp_rsp),
		.drp_req         (drp_req),
		.adc_reset       (adc_reset),
		.die_temp        (die_temp),
		.volt_core       (volt_core),
		.volt_aux        (volt_aux),
		.volt_ram        (volt_ram),
		.ext_in          (ext_in),
		.die_temp_native (die_temp_native),
		.sensors_update  (sensors_update),
		.ext_update      (ext_update)
	);

	drp_adc_model adc_model_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.code_table (code_table),
		.delays     (delays),
		.stall_arm  (stall_arm),
		.stall_addr (7'd21),	// Channel 5 of the sweep
		.drp_req    (drp_req),
		.drp_rsp    (drp_rsp)
	);

	sensor_checker sensor_checker_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.test_name       (test_name),
		.code_table      (code_table),
		.expect_no_ext   (expect_no_ext),
		.adc_reset       (adc_reset),
		.drp_en          (drp_req.en),
		.drp_we          (drp_req.we),
		.die_temp        (die_temp),
		.volt_core       (volt_core),
		.volt_aux        (volt_aux),
		.volt_ram        (volt_ram),
		.ext_in          (ext_in),
		.die_temp_native (die_temp_native),
		.sensors_update  (sensors_update),
		.ext_update      (ext_update),
		.check_count     (check_count),
		.error_count     (error_count)
	);

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i]       = lfsr_state[0];	// One step per bit
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic fill_tables();
		logic [31:0] v;
		for (int i = 0; i < 32; i++) begin
			take_bits(16, v);
			code_table[i] <= v[15:0];
		end
		for (int j = 0; j < 64; j++) begin
			take_bits(3, v);
			delays[j] <= 3'(v % 6 + 1);	// 1 to 6 cycles
		end
	endtask

	function automatic bit event_seen(input int sel);
		case (sel)
			EV_BANK:      return sensors_update;
			EV_EXT:       return ext_update;
			EV_RESET_LOW: return !adc_reset;
			default:      return drp_req.en;
		endcase
	endfunction

	task automatic wait_event(input int sel, input int limit, input string what);
		int n;
		bit seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < limit) begin
			@(posedge clk);
			n++;
			seen = event_seen(sel);
		end
		if (!seen) begin
			$display("Timeout: no %0s within %0d cycles", what, limit);
			hung = 1'b1;
		end
	endtask

	task automatic begin_test(input logic [8*16-1:0] name);
		@(posedge clk);
		test_name <= name;
	endtask

	// The checker is done with this edge by the falling edge
	task automatic end_test();
		@(negedge clk);
		$display("Test %0s done: %0d checks, %0d errors", test_name,
			check_count - base_checks, error_count - base_errors);
		base_checks = check_count;
		base_errors = error_count;
	endtask

	task automatic run_tests();
		wait_event(EV_RESET_LOW, 4 * PWRUP_CYCLES, "adc_reset release");
		if (hung) return;
		wait_event(EV_FIRST_READ, 4 * PWRUP_CYCLES, "first DRP read");
		if (hung) return;
		end_test();

		begin_test("first_bank");	// Temperature and the three rails
		wait_event(EV_BANK, ROUND_LIMIT, "sensors_update");
		if (hung) return;
		end_test();

		begin_test("first_ext");
		wait_event(EV_EXT, ROUND_LIMIT, "ext_update");
		if (hung) return;
		end_test();

		begin_test("new_table");
		fill_tables();
		wait_event(EV_BANK, ROUND_LIMIT, "sensors_update with new codes");
		if (hung) return;
		wait_event(EV_EXT, ROUND_LIMIT, "ext_update with new codes");
		if (hung) return;
		end_test();

		// Stalled sweep followed by a clean round
		begin_test("watchdog");
		stall_arm     <= 1'b1;
		expect_no_ext <= 1'b1;
		wait_event(EV_BANK, ROUND_LIMIT, "sensors_update before the stall");
		if (hung) return;
		wait_event(EV_BANK, WATCHDOG_CYCLES + ROUND_LIMIT, "sensors_update after the abort");
		if (hung) return;
		stall_arm     <= 1'b0;
		expect_no_ext <= 1'b0;
		wait_event(EV_EXT, ROUND_LIMIT, "ext_update after the abort");
		if (hung) return;
		end_test();
	endtask

	initial begin
		rst_n         <= 1'b0;
		stall_arm     <= 1'b0;
		expect_no_ext <= 1'b0;
		test_name     <= "power_up";
		fill_tables();
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		run_tests();
		$display("Totals: %0d checks, %0d errors, %0d timeouts", check_count, error_count,
			hung ? 1 : 0);
		if (hung || error_count != 0)
			$display("SIMULATION FAILED");
		else
			$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: files.f
rtl/sensor_pkg.sv
rtl/adc_poll_ctrl.sv
rtl/sensor_scaler.sv
rtl/sensor_regs.sv
rtl/on_die_sensors.sv
bench/drp_adc_model.sv
bench/sensor_checker.sv
bench/tb_on_die_sensors.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the sensor poller testbench with Verilator, run it and scan the log

set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -sv -f files.f \
	--top-module tb_on_die_sensors -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
	echo "No result line found in $LOG"
	exit 1
fi
exit 0
